// ==== bench/cache_properties.sv ====
// concurrent assertions on the shared slow memory port
`default_nettype none

module cache_properties (
	input logic                clk,
	input logic                proc_reset,
	input cache_pkg::mem_req_t mem_req,
	input cache_pkg::mem_rsp_t mem_rsp
);

	// failed assertions so far, summed up by the testbench
	int fail_count = 0;

	// ----------------------------------------------------------------------
	// request shape
	// ----------------------------------------------------------------------
	one_direction: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write))
	else begin
		fail_count++;
		$error("memory read and write are high together");
	end

	// a waiting request stays put until ready
	hold_until_ready: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_req.read || mem_req.write) && !mem_rsp.ready |=>
			$stable(mem_req.read) && $stable(mem_req.write) &&
			$stable(mem_req.addr) && $stable(mem_req.wdata))
	else begin
		fail_count++;
		$error("memory request changed before ready");
	end

	// port quiet once reset has been applied
	idle_after_reset: assert property (@(posedge clk)
		proc_reset |=> !mem_req.read && !mem_req.write)
	else begin
		fail_count++;
		$error("memory request active right after reset");
	end

endmodule

`default_nettype wire

// ==== bench/tb_cache_subsystem.sv ====
// testbench with clock, reset, slow memory model, directed cache tests and summary
`default_nettype none
`include "cache_defs.svh"

module tb_cache_subsystem;

	logic                  clk;
	logic                  proc_reset;
	logic                  inst_read;
	cache_pkg::word_addr_t inst_addr;
	logic [`WORD_W-1:0]    inst_rdata;
	logic                  inst_stall;
	cache_pkg::proc_req_t  data_req;
	logic [`WORD_W-1:0]    data_rdata;
	logic                  data_stall;
	cache_pkg::mem_req_t   mem_req;
	cache_pkg::mem_rsp_t   mem_rsp;

	// memory model, written lines override the fill rule
	logic [`LINE_W-1:0]     stored [logic [`MEM_ADDR_W-1:0]];
	integer                 seed = 32'hb0aa605d;
	int                     remaining = 0;
	logic                   busy = 1'b0;
	int                     mem_reads = 0;
	int                     mem_writes = 0;
	logic [`MEM_ADDR_W-1:0] last_wr_addr;
	cache_pkg::line_u       last_wr_line;
	int                     errors = 0;
	int                     cycles = 0;

	cache_subsystem dut0 (.*);
	bind cache_subsystem cache_properties props0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// fill rule, word w of line a with the upper 16 bits inverted
	function automatic logic [`WORD_W-1:0] rule_word(input logic [`MEM_ADDR_W-1:0] a,
		input int w);
		return (32'(a) * 32'd16 + 32'(w)) ^ 32'hffff_0000;
	endfunction

	function automatic logic [`WORD_W-1:0] rule_at(input cache_pkg::word_addr_t a);
		return rule_word({a.tag, a.index}, a.offset);
	endfunction

	function automatic cache_pkg::word_addr_t make_addr(input int tag, input int index,
		input int offset);
		return {tag[`TAG_W-1:0], index[`INDEX_W-1:0], offset[`OFFSET_W-1:0]};
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	// ----------------------------------------------------------------------
	// slow memory, ready pulse after 1 to 4 cycles
	// ----------------------------------------------------------------------
	always @(negedge clk) begin : memory_model
		if (proc_reset || mem_rsp.ready) begin
			mem_rsp.ready = 1'b0;
			busy          = 1'b0;
		end else if (mem_req.read || mem_req.write) begin
			if (!busy) begin
				busy      = 1'b1;
				remaining = $random(seed) & 3;
			end
			if (remaining == 0) begin
				mem_rsp.ready = 1'b1;
				if (mem_req.write) begin
					stored[mem_req.addr] = mem_req.wdata.flat;
					last_wr_addr         = mem_req.addr;
					last_wr_line         = mem_req.wdata;
					mem_writes++;
				end else begin
					mem_rsp.rdata.flat = stored.exists(mem_req.addr) ?
						stored[mem_req.addr] : '0;
					if (!stored.exists(mem_req.addr)) begin
						for (int w = 0; w < `LINE_WORDS; w++) begin
							mem_rsp.rdata.words[w] = rule_word(mem_req.addr, w);
						end
					end
					mem_reads++;
				end
			end else begin
				remaining--;
			end
		end
	end

	// directed tests take a few hundred cycles, 3000 is far beyond that
	always @(posedge clk) begin : watchdog
		cycles++;
		if (cycles >= 3000) begin
			$display("Timeout: the tests did not finish within 3000 cycles");
			$display("Some tests failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// processor side accesses, sampled 10 units before the rising edge
	// ----------------------------------------------------------------------
	task automatic fetch_inst(input int tag, input int index, input int offset,
		input bit hit);
		cache_pkg::word_addr_t a;
		int waited;
		a      = make_addr(tag, index, offset);
		waited = 0;
		@(negedge clk);
		inst_read = 1'b1;
		inst_addr = a;
		#10;
		while (inst_stall) begin
			waited++;
			@(negedge clk);
			#10;
		end
		assert (inst_rdata === rule_at(a)) else report_fail($sformatf(
			"inst read %h: got %h, expected %h", a, inst_rdata, rule_at(a)));
		assert ((waited == 0) == hit) else report_fail($sformatf(
			"inst read %h: %0d stall cycles, hit expected %0b", a, waited, hit));
	endtask

	// value is the expected word on a read and the store data on a write
	task automatic access_data(input bit wr, input cache_pkg::word_addr_t a,
		input logic [`WORD_W-1:0] value, input bit hit);
		int waited = 0;
		@(negedge clk);
		data_req.read  = !wr;
		data_req.write = wr;
		data_req.addr  = a;
		data_req.wdata = value;
		#10;
		while (data_stall) begin
			waited++;
			@(negedge clk);
			#10;
		end
		if (!wr) begin
			assert (data_rdata === value) else report_fail($sformatf(
				"data read %h: got %h, expected %h", a, data_rdata, value));
		end
		assert ((waited == 0) == hit) else report_fail($sformatf(
			"data access %h: %0d stall cycles, hit expected %0b", a, waited, hit));
	endtask

	task automatic rule_read(input int tag, input int index, input int offset,
		input bit hit);
		access_data(1'b0, make_addr(tag, index, offset),
			rule_at(make_addr(tag, index, offset)), hit);
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	initial begin : stimulus
		cache_pkg::word_addr_t a;
		int reads0;
		int writes0;
		proc_reset = 1'b1;
		inst_read  = 1'b0;
		inst_addr  = '0;
		data_req   = '0;
		mem_rsp    = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		proc_reset = 1'b0;
		#10;
		assert (!inst_stall && !data_stall && !mem_req.read && !mem_req.write)
			else report_fail("stall or memory request high after reset");

		// 1. instruction miss, then every word of the line hits
		reads0 = mem_reads;
		fetch_inst(5, 1, 0, 1'b0);
		for (int w = 0; w < `LINE_WORDS; w++) begin
			fetch_inst(5, 1, w, 1'b1);
		end
		assert (mem_reads == reads0 + 1) else report_fail("inst line fetched more than once");

		// 2. data fill, one word written, whole line read back
		rule_read(9, 0, 2, 1'b0);
		access_data(1'b1, make_addr(9, 0, 1), 32'hdead_beef, 1'b1);
		for (int w = 0; w < `LINE_WORDS; w++) begin
			a = make_addr(9, 0, w);
			access_data(1'b0, a, (w == 1) ? 32'hdead_beef : rule_at(a), 1'b1);
		end

		// 3. lru in set 2, C replaces B and A stays
		rule_read(20, 2, 0, 1'b0);
		rule_read(21, 2, 0, 1'b0);
		rule_read(20, 2, 1, 1'b1);
		rule_read(22, 2, 0, 1'b0);
		reads0 = mem_reads;
		rule_read(20, 2, 2, 1'b1);
		assert (mem_reads == reads0) else report_fail("set 2: tag A fetched again");
		rule_read(21, 2, 3, 1'b0);
		assert (mem_reads == reads0 + 1) else report_fail("set 2: tag B was not refetched");

		// 4. dirty A in set 3 is pushed out by B and C
		a = make_addr(30, 3, 2);
		rule_read(30, 3, 0, 1'b0);
		access_data(1'b1, a, 32'h1234_5678, 1'b1);
		rule_read(31, 3, 0, 1'b0);
		writes0 = mem_writes;
		rule_read(32, 3, 0, 1'b0);
		assert (mem_writes == writes0 + 1 && last_wr_addr == {a.tag, a.index} &&
			last_wr_line.words[2] == 32'h1234_5678 &&
			last_wr_line.words[0] == rule_word({a.tag, a.index}, 0))
			else report_fail("dirty line of tag A not written back correctly");
		access_data(1'b0, a, 32'h1234_5678, 1'b0);
		rule_read(30, 3, 1, 1'b1);

		// 5. instruction and data misses in the same cycle
		reads0 = mem_reads;
		fork
			fetch_inst(40, 0, 3, 1'b0);
			rule_read(41, 1, 2, 1'b0);
		join
		assert (mem_reads == reads0 + 2) else report_fail("shared port did not serve both misses");

		// data miss one cycle behind an instruction refill that owns the port
		reads0 = mem_reads;
		for (int i = 0; i < 3; i++) begin
			fork
				fetch_inst(50 + i, 2, i, 1'b0);
				begin
					@(negedge clk);
					rule_read(60 + i, 1, i, 1'b0);
				end
			join
		end
		assert (mem_reads == reads0 + 6)
			else report_fail("staggered misses were not all served");

		@(negedge clk);
		inst_read = 1'b0;
		data_req  = '0;
		repeat (2) @(posedge clk);
		$display("Summary: %0d check errors, %0d assertion errors",
			errors, dut0.props0.fail_count);
		if (errors == 0 && dut0.props0.fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/inst_cache.sv
verilog/data_cache.sv
verilog/mem_arbiter.sv
verilog/cache_subsystem.sv
bench/cache_properties.sv
bench/tb_cache_subsystem.sv

// ==== verilog/cache_defs.svh ====
// width and geometry macros for the caches and the line-wide memory port
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// ----------------------------------------------------------------------
// processor side
// ----------------------------------------------------------------------
`define WORD_W      32
`define ADDR_W      30

// word select inside a line, then set index
`define OFFSET_W    2
`define INDEX_W     2

// whatever is left above index and offset
`define TAG_W       (`ADDR_W - `INDEX_W - `OFFSET_W)

// ----------------------------------------------------------------------
// line geometry and memory port
// ----------------------------------------------------------------------
`define LINE_WORDS  4
`define LINE_W      (`LINE_WORDS * `WORD_W)
`define NUM_SETS    (1 << `INDEX_W)
// memory is addressed by line, so tag and index only
`define MEM_ADDR_W  (`TAG_W + `INDEX_W)

`endif

// ==== verilog/cache_pkg.sv ====
// shared structs, cache line union and data cache state enum
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

	// processor word address split for set lookup
	typedef struct packed {
		logic [`TAG_W-1:0]    tag;
		logic [`INDEX_W-1:0]  index;
		logic [`OFFSET_W-1:0] offset;
	} word_addr_t;

	// one line, whole for memory transfers or per word for the processor
	// word 0 sits in the low 32 bits
	typedef union packed {
		logic [`LINE_W-1:0]                  flat;
		logic [`LINE_WORDS-1:0][`WORD_W-1:0] words;
	} line_u;

	// data side processor request
	typedef struct packed {
		logic                 read;
		logic                 write;
		word_addr_t           addr;
		logic [`WORD_W-1:0]   wdata;
	} proc_req_t;

	// line request toward slow memory, held until ready
	typedef struct packed {
		logic                    read;
		logic                    write;
		logic [`MEM_ADDR_W-1:0]  addr;
		line_u                   wdata;
	} mem_req_t;

	// ready is a single-cycle completion pulse
	typedef struct packed {
		logic  ready;
		line_u rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic              valid;
		logic [`TAG_W-1:0] tag;
		line_u             data;
	} iway_t;

	typedef struct packed {
		logic              valid;
		logic              dirty;
		logic [`TAG_W-1:0] tag;
		line_u             data;
	} dway_t;

	typedef enum logic [1:0] {
		compare_tag = 2'd0,
		write_back  = 2'd1,
		allocate    = 2'd2
	} dcache_state_e;

endpackage

`default_nettype wire

// ==== verilog/cache_subsystem.sv ====
// top level with instruction cache, data cache and memory arbiter
`default_nettype none
`include "cache_defs.svh"

module cache_subsystem (
	input  logic                  clk,
	input  logic                  proc_reset,
	// instruction fetch side
	input  logic                  inst_read,
	input  cache_pkg::word_addr_t inst_addr,
	output logic [`WORD_W-1:0]    inst_rdata,
	output logic                  inst_stall,
	// load and store side
	input  cache_pkg::proc_req_t  data_req,
	output logic [`WORD_W-1:0]    data_rdata,
	output logic                  data_stall,
	// shared slow memory
	output cache_pkg::mem_req_t   mem_req,
	input  cache_pkg::mem_rsp_t   mem_rsp
);

	// cache to arbiter
	cache_pkg::mem_req_t inst_mem_req;
	cache_pkg::mem_rsp_t inst_mem_rsp;
	cache_pkg::mem_req_t data_mem_req;
	cache_pkg::mem_rsp_t data_mem_rsp;

	inst_cache icache0 (
		.clk        (clk),
		.proc_reset (proc_reset),
		.read       (inst_read),
		.addr       (inst_addr),
		.rdata      (inst_rdata),
		.stall      (inst_stall),
		.mem_req    (inst_mem_req),
		.mem_rsp    (inst_mem_rsp)
	);

	data_cache dcache0 (
		.clk        (clk),
		.proc_reset (proc_reset),
		.req        (data_req),
		.rdata      (data_rdata),
		.stall      (data_stall),
		.mem_req    (data_mem_req),
		.mem_rsp    (data_mem_rsp)
	);

	mem_arbiter arb0 (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.inst_mem_req (inst_mem_req),
		.inst_mem_rsp (inst_mem_rsp),
		.data_mem_req (data_mem_req),
		.data_mem_rsp (data_mem_rsp),
		.mem_req      (mem_req),
		.mem_rsp      (mem_rsp)
	);

endmodule

`default_nettype wire

// ==== verilog/data_cache.sv ====
// write-back two-way set-associative data cache with dirty victim write-back
`default_nettype none
`include "cache_defs.svh"

module data_cache (
	input  logic                 clk,
	input  logic                 proc_reset,
	input  cache_pkg::proc_req_t req,
	output logic [`WORD_W-1:0]   rdata,
	output logic                 stall,
	output cache_pkg::mem_req_t  mem_req,
	input  cache_pkg::mem_rsp_t  mem_rsp
);

	// ----------------------------------------------------------------------
	// storage and state
	// ----------------------------------------------------------------------
	// ways[w][set], valid and dirty travel with the line
	cache_pkg::dway_t         ways [0:1][0:`NUM_SETS-1];
	// per set, way to be replaced next
	logic [`NUM_SETS-1:0]     lru;
	cache_pkg::dcache_state_e state;

	logic [1:0]        hit;
	logic              hit_any;
	logic              access;
	logic              victim;
	logic              victim_dirty;
	cache_pkg::dway_t  victim_line;

	// ----------------------------------------------------------------------
	// lookup
	// ----------------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit[w] = ways[w][req.addr.index].valid &&
				(ways[w][req.addr.index].tag == req.addr.tag);
		end
	end

	assign access  = req.read | req.write;
	assign hit_any = hit[0] | hit[1];

	// victim comes from lru, clean or dirty decides the path
	assign victim       = lru[req.addr.index];
	assign victim_line  = ways[victim][req.addr.index];
	assign victim_dirty = victim_line.valid & victim_line.dirty;

	// selected word of the hit way
	assign rdata = ways[hit[1]][req.addr.index].data.words[req.addr.offset];

	// ----------------------------------------------------------------------
	// processor stall and memory request
	// ----------------------------------------------------------------------
	always_comb begin
		stall   = 1'b1;
		mem_req = '0;
		case (state)
			cache_pkg::compare_tag: begin
				// only a miss stalls here
				stall = access & ~hit_any;
			end
			cache_pkg::write_back: begin
				// old line goes back to its own tag and index
				mem_req.write = 1'b1;
				mem_req.addr  = {victim_line.tag, req.addr.index};
				mem_req.wdata = victim_line.data;
			end
			cache_pkg::allocate: begin
				mem_req.read = 1'b1;
				mem_req.addr = {req.addr.tag, req.addr.index};
			end
			default: begin
				stall = 1'b1;
			end
		endcase
	end

	// ----------------------------------------------------------------------
	// state and array update
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			// straight into compare_tag with everything invalid
			state <= cache_pkg::compare_tag;
			lru   <= '0;
			for (int s = 0; s < `NUM_SETS; s++) begin
				ways[0][s].valid <= 1'b0;
				ways[0][s].dirty <= 1'b0;
				ways[1][s].valid <= 1'b0;
				ways[1][s].dirty <= 1'b0;
			end
		end else begin
			case (state)
				cache_pkg::compare_tag: begin
					if (access && hit_any) begin
						lru[req.addr.index] <= hit[0];
						if (req.write) begin
							// one word through the word view, line now dirty
							ways[hit[1]][req.addr.index].data.words[req.addr.offset] <=
								req.wdata;
							ways[hit[1]][req.addr.index].dirty <= 1'b1;
						end
					end else if (access) begin
						if (victim_dirty) begin
							state <= cache_pkg::write_back;
						end else begin
							state <= cache_pkg::allocate;
						end
					end
				end
				cache_pkg::write_back: begin
					if (mem_rsp.ready) begin
						ways[victim][req.addr.index].dirty <= 1'b0;
						state <= cache_pkg::allocate;
					end
				end
				cache_pkg::allocate: begin
					if (mem_rsp.ready) begin
						// fresh line lands clean
						ways[victim][req.addr.index].valid <= 1'b1;
						ways[victim][req.addr.index].dirty <= 1'b0;
						ways[victim][req.addr.index].tag   <= req.addr.tag;
						ways[victim][req.addr.index].data  <= mem_rsp.rdata;
						lru[req.addr.index] <= ~victim;
						state <= cache_pkg::compare_tag;
					end
				end
				default: begin
					state <= cache_pkg::compare_tag;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/inst_cache.sv ====
// read-only two-way set-associative instruction cache with lru refill
`default_nettype none
`include "cache_defs.svh"

module inst_cache (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  logic                  read,
	input  cache_pkg::word_addr_t addr,
	output logic [`WORD_W-1:0]    rdata,
	output logic                  stall,
	output cache_pkg::mem_req_t   mem_req,
	input  cache_pkg::mem_rsp_t   mem_rsp
);

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	// ways[w][set]
	cache_pkg::iway_t     ways [0:1][0:`NUM_SETS-1];
	// per set, names the way to replace next
	logic [`NUM_SETS-1:0] lru;
	// read request outstanding on the memory port
	logic                 allocating;

	logic [1:0] hit;
	logic       hit_any;
	logic       victim;

	// ----------------------------------------------------------------------
	// lookup
	// ----------------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit[w] = ways[w][addr.index].valid &&
				(ways[w][addr.index].tag == addr.tag);
		end
	end

	assign hit_any = hit[0] | hit[1];
	assign victim  = lru[addr.index];

	// word of the hitting way, way 1 only when it hits
	assign rdata = ways[hit[1]][addr.index].data.words[addr.offset];

	// held until the refilled line hits
	assign stall = read & ~hit_any;

	// line fetch for the requested address, never a write
	always_comb begin
		mem_req       = '0;
		mem_req.read  = allocating;
		mem_req.addr  = {addr.tag, addr.index};
	end

	// ----------------------------------------------------------------------
	// update
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			allocating <= 1'b0;
			lru        <= '0;
			for (int s = 0; s < `NUM_SETS; s++) begin
				ways[0][s].valid <= 1'b0;
				ways[1][s].valid <= 1'b0;
			end
		end else begin
			if (allocating && mem_rsp.ready) begin
				// fill the lru way, the other one goes next
				allocating                      <= 1'b0;
				ways[victim][addr.index].valid  <= 1'b1;
				ways[victim][addr.index].tag    <= addr.tag;
				ways[victim][addr.index].data   <= mem_rsp.rdata;
				lru[addr.index]                 <= ~victim;
			end else if (read && !hit_any) begin
				allocating <= 1'b1;
			end else if (read && hit_any) begin
				// recently used way stays, point at the other
				lru[addr.index] <= hit[0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
// slow memory port arbiter between the caches with data priority and owner lock
`default_nettype none

module mem_arbiter (
	input  logic                clk,
	input  logic                proc_reset,
	input  cache_pkg::mem_req_t inst_mem_req,
	output cache_pkg::mem_rsp_t inst_mem_rsp,
	input  cache_pkg::mem_req_t data_mem_req,
	output cache_pkg::mem_rsp_t data_mem_rsp,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp
);

	// owner held until ready
	logic locked;
	logic owner_data;

	logic inst_active;
	logic data_active;
	logic sel_data;
	logic sel_active;

	// ----------------------------------------------------------------------
	// selection
	// ----------------------------------------------------------------------
	assign inst_active = inst_mem_req.read | inst_mem_req.write;
	assign data_active = data_mem_req.read | data_mem_req.write;

	// data cache wins whenever the port is free
	assign sel_data   = locked ? owner_data : data_active;
	assign sel_active = sel_data ? data_active : inst_active;

	// no register on the request path
	assign mem_req = sel_data ? data_mem_req : inst_mem_req;

	// the loser sees ready low and keeps holding
	always_comb begin
		inst_mem_rsp = '0;
		data_mem_rsp = '0;
		if (sel_data) begin
			data_mem_rsp = mem_rsp;
		end else begin
			inst_mem_rsp = mem_rsp;
		end
	end

	// ----------------------------------------------------------------------
	// lock
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			locked     <= 1'b0;
			owner_data <= 1'b0;
		end else if (locked) begin
			if (mem_rsp.ready) begin
				locked <= 1'b0;
			end
		end else if (sel_active && !mem_rsp.ready) begin
			locked     <= 1'b1;
			owner_data <= sel_data;
		end
	end

endmodule

`default_nettype wire
